// ==== common/spw_tx_pkg.sv ====
// SpaceWire transmitter shared definitions
`default_nettype none

package spw_tx_pkg;

  // ------------------------------
  // Field widths
  // ------------------------------
  localparam int divide_w = 6;
  localparam int credit_w = 6;
  localparam int time_w   = 6;
  localparam int flags_w  = 2;

  // Credit added per received FCT
  localparam int credit_per_fct = 8;
  // Highest credit the count may hold
  localparam int credit_max     = 56;

  // ------------------------------
  // Control codes, bit 0 goes on the line first
  // ------------------------------
  localparam logic [1:0] code_fct = 2'b00;
  localparam logic [1:0] code_eop = 2'b10;
  localparam logic [1:0] code_eep = 2'b01;
  localparam logic [1:0] code_esc = 2'b11;

  // Character chosen by the scheduler for the next parity slot
  typedef enum logic [3:0] {
    kind_none      = 4'd0,
    kind_null_esc  = 4'd1,
    kind_null_fct  = 4'd2,
    kind_fct       = 4'd3,
    kind_time_esc  = 4'd4,
    kind_time_data = 4'd5,
    kind_data      = 4'd6,
    kind_eop       = 4'd7,
    kind_eep       = 4'd8
  } char_kind_t;

endpackage

`default_nettype wire

// ==== hw/spw_bit_rate_divider.sv ====
// Transmit bit rate divider
`timescale 1ns/1ps
`default_nettype none

module spw_bit_rate_divider import spw_tx_pkg::*;
#(
  parameter logic [divide_w-1:0] default_divide = 6'd9
)
(
  input  wire                 i_tx_clk,
  input  wire                 reset_in,
  input  wire                 i_send_n_char,
  input  wire  [divide_w-1:0] i_tx_clk_divide,
  output logic                o_bit_tick
);

  logic [divide_w-1:0] divide_reg;
  logic [divide_w-1:0] divide_count;

  // Start-up rate holds until N-Chars are enabled
  always_ff @(posedge i_tx_clk or posedge reset_in)
  begin
    if (reset_in)
    begin
      divide_reg <= default_divide;
    end
    else if (i_send_n_char)
    begin
      divide_reg <= i_tx_clk_divide;
    end
    else
    begin
      divide_reg <= default_divide;
    end
  end

  // One tick every divide_reg + 1 cycles
  always_ff @(posedge i_tx_clk or posedge reset_in)
  begin
    if (reset_in)
    begin
      divide_count <= '0;
      o_bit_tick   <= 1'b0;
    end
    else if (divide_count >= divide_reg)
    begin
      divide_count <= '0;
      o_bit_tick   <= 1'b1;
    end
    else
    begin
      divide_count <= divide_count + 1'b1;
      o_bit_tick   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/spw_credit_counter.sv ====
// Transmit credit counter
`timescale 1ns/1ps
`default_nettype none

module spw_credit_counter import spw_tx_pkg::*;
(
  input  wire                 i_tx_clk,
  input  wire                 reset_in,
  input  wire                 i_got_fct,
  input  wire                 i_n_char_sent,
  output logic [credit_w-1:0] o_credit_count,
  output logic                o_credit_zero,
  output logic                o_credit_error
);

  logic fct_ok;
  logic fct_overflow;

  // An FCT is honoured only if the result stays within credit_max
  always_comb
  begin
    fct_ok       = i_got_fct && (int'(o_credit_count) + credit_per_fct <= credit_max);
    fct_overflow = i_got_fct && !fct_ok;
  end

  assign o_credit_zero = (o_credit_count == '0);

  always_ff @(posedge i_tx_clk or posedge reset_in)
  begin
    if (reset_in)
    begin
      o_credit_count <= '0;
      o_credit_error <= 1'b0;
    end
    else
    begin
      // FCT pulses are single cycle, so the error is too
      o_credit_error <= fct_overflow;
      if (fct_ok && i_n_char_sent)
      begin
        // Increment and decrement together
        o_credit_count <= o_credit_count + credit_w'(credit_per_fct - 1);
      end
      else if (fct_ok)
      begin
        o_credit_count <= o_credit_count + credit_w'(credit_per_fct);
      end
      else if (i_n_char_sent && !o_credit_zero)
      begin
        // Never below zero
        o_credit_count <= o_credit_count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== encoder/spw_char_scheduler.sv ====
// Transmit character scheduler
`timescale 1ns/1ps
`default_nettype none

module spw_char_scheduler import spw_tx_pkg::*;
(
  input  wire                i_tx_clk,
  input  wire                reset_in,
  input  wire                i_send_nulls,
  input  wire                i_send_n_char,
  input  wire                i_send_time_codes,
  input  wire                i_tx_data_en,
  input  wire  [7:0]         i_tx_data,
  input  wire                i_tx_data_control_flag,
  input  wire                i_tick_in,
  input  wire  [time_w-1:0]  i_time_in,
  input  wire  [flags_w-1:0] i_control_flags_in,
  input  wire                i_fct_req,
  input  wire                i_credit_zero,
  input  wire                i_char_load,
  output logic               o_tx_ready,
  output char_kind_t         o_next_kind,
  output logic [7:0]         o_next_data,
  output logic               o_n_char_sent
);

  // Pending request flags
  logic data_pending;
  logic time_pending;
  logic fct_pending;
  // Second halves of two-part characters
  logic null_half;
  logic time_half;
  logic first_null_sent;

  // Captured payloads
  logic [7:0]         data_buf;
  logic               data_flag_buf;
  logic [time_w-1:0]  time_buf;
  logic [flags_w-1:0] flags_buf;

  logic data_accept;
  logic tick_accept;

  assign o_tx_ready  = !data_pending && !i_credit_zero;
  assign data_accept = i_tx_data_en && o_tx_ready;
  // A tick during a pending Time-Code is dropped
  assign tick_accept = i_tick_in && i_send_time_codes && !time_pending;

  // ------------------------------
  // Priority pick
  // ------------------------------
  always_comb
  begin
    if (null_half)
      o_next_kind = kind_null_fct;
    else if (time_half)
      o_next_kind = kind_time_data;
    else if (time_pending)
      o_next_kind = kind_time_esc;
    else if (fct_pending && first_null_sent)
      o_next_kind = kind_fct;
    else if (data_pending && i_send_n_char)
    begin
      // Control byte bit 0 selects EOP or EEP
      if (!data_flag_buf)
        o_next_kind = kind_data;
      else if (data_buf[0])
        o_next_kind = kind_eep;
      else
        o_next_kind = kind_eop;
    end
    else if (i_send_nulls)
      o_next_kind = kind_null_esc;
    else
      o_next_kind = kind_none;
  end

  // Time-Code byte is flags above time
  assign o_next_data   = time_half ? {flags_buf, time_buf} : data_buf;
  assign o_n_char_sent = i_char_load && (o_next_kind == kind_data ||
                                         o_next_kind == kind_eop  ||
                                         o_next_kind == kind_eep);

  // ------------------------------
  // Request state
  // ------------------------------
  always_ff @(posedge i_tx_clk or posedge reset_in)
  begin
    if (reset_in)
    begin
      data_pending    <= 1'b0;
      time_pending    <= 1'b0;
      fct_pending     <= 1'b0;
      null_half       <= 1'b0;
      time_half       <= 1'b0;
      first_null_sent <= 1'b0;
    end
    else
    begin
      // Clear what the serializer just took
      if (i_char_load)
      begin
        case (o_next_kind)
          kind_null_esc:  null_half <= 1'b1;
          kind_null_fct:
          begin
            null_half       <= 1'b0;
            first_null_sent <= 1'b1;
          end
          kind_time_esc:  time_half <= 1'b1;
          kind_time_data:
          begin
            time_half    <= 1'b0;
            time_pending <= 1'b0;
          end
          kind_fct:       fct_pending <= 1'b0;
          kind_data, kind_eop, kind_eep: data_pending <= 1'b0;
          default:        ;
        endcase
      end
      // New requests
      if (data_accept)
        data_pending <= 1'b1;
      if (tick_accept)
        time_pending <= 1'b1;
      if (i_fct_req)
        fct_pending <= 1'b1;
    end
  end

  // Payload capture
  always_ff @(posedge i_tx_clk)
  begin
    if (data_accept)
    begin
      data_buf      <= i_tx_data;
      data_flag_buf <= i_tx_data_control_flag;
    end
    if (tick_accept)
    begin
      time_buf  <= i_time_in;
      flags_buf <= i_control_flags_in;
    end
  end

endmodule

`default_nettype wire

// ==== encoder/spw_ds_serializer.sv ====
// Data-strobe serializer
`timescale 1ns/1ps
`default_nettype none

module spw_ds_serializer import spw_tx_pkg::*;
(
  input  wire         i_tx_clk,
  input  wire         reset_in,
  input  wire         i_tx_en,
  input  wire         i_send_nulls,
  input  wire         i_bit_tick,
  input  char_kind_t  i_next_kind,
  input  wire  [7:0]  i_next_data,
  output logic        o_char_load,
  output logic        o_space_wire_data_out,
  output logic        o_space_wire_strobe_out
);

  typedef enum logic [1:0] {
    st_stop,
    st_parity,
    st_flag,
    st_shift
  } tx_state_t;

  tx_state_t  state;
  logic       flag_reg;
  logic [7:0] shift_reg;
  logic [2:0] bit_count;
  // XOR of the payload bits of the character in flight
  logic       parity_acc;

  logic       load_valid;
  logic       load_ctrl;
  logic [7:0] load_bits;
  logic [2:0] load_count;
  logic       line_bit;
  logic       line_drive;

  // Next character wanted at each parity slot
  assign o_char_load = i_bit_tick && i_tx_en && (state == st_parity);

  // ------------------------------
  // Character decode
  // ------------------------------
  always_comb
  begin
    load_valid = 1'b1;
    load_ctrl  = 1'b1;
    load_bits  = '0;
    load_count = 3'd1;
    case (i_next_kind)
      kind_data, kind_time_data:
      begin
        load_ctrl  = 1'b0;
        load_bits  = i_next_data;
        load_count = 3'd7;
      end
      kind_null_esc, kind_time_esc: load_bits = {6'b0, code_esc};
      kind_null_fct, kind_fct:      load_bits = {6'b0, code_fct};
      kind_eop:                     load_bits = {6'b0, code_eop};
      kind_eep:                     load_bits = {6'b0, code_eep};
      // Nothing to send, hold the line
      default:                      load_valid = 1'b0;
    endcase
  end

  // Bit for this period; odd parity over last payload plus new flag
  always_comb
  begin
    case (state)
      st_parity: line_bit = ~(parity_acc ^ load_ctrl);
      st_flag:   line_bit = flag_reg;
      st_shift:  line_bit = shift_reg[0];
      default:   line_bit = 1'b0;
    endcase
    line_drive = i_bit_tick && i_tx_en &&
                 (state == st_flag || state == st_shift ||
                  (state == st_parity && load_valid));
  end

  // ------------------------------
  // Line FSM
  // ------------------------------
  always_ff @(posedge i_tx_clk or posedge reset_in)
  begin
    if (reset_in)
    begin
      state                   <= st_stop;
      flag_reg                <= 1'b0;
      shift_reg               <= '0;
      bit_count               <= '0;
      parity_acc              <= 1'b0;
      o_space_wire_data_out   <= 1'b0;
      o_space_wire_strobe_out <= 1'b0;
    end
    else if (i_bit_tick)
    begin
      if (state == st_stop)
      begin
        if (i_tx_en && i_send_nulls)
          state <= st_parity;
        else
        begin
          o_space_wire_data_out   <= 1'b0;
          o_space_wire_strobe_out <= 1'b0;
          parity_acc              <= 1'b0;
        end
      end
      else if (!i_tx_en)
      begin
        // Link disabled mid-character
        o_space_wire_data_out <= 1'b0;
        state                 <= st_stop;
      end
      else
      begin
        case (state)
          st_parity:
          begin
            if (load_valid)
            begin
              flag_reg  <= load_ctrl;
              shift_reg <= load_bits;
              bit_count <= load_count;
              state     <= st_flag;
            end
          end
          st_flag:
          begin
            parity_acc <= 1'b0;
            state      <= st_shift;
          end
          default:
          begin
            parity_acc <= parity_acc ^ shift_reg[0];
            shift_reg  <= {1'b0, shift_reg[7:1]};
            bit_count  <= bit_count - 1'b1;
            if (bit_count == '0)
              state <= st_parity;
          end
        endcase
      end
      // Strobe toggles when data repeats
      if (line_drive)
      begin
        o_space_wire_data_out   <= line_bit;
        o_space_wire_strobe_out <= o_space_wire_strobe_out ^
                                   (line_bit == o_space_wire_data_out);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/spw_tx_top.sv ====
// SpaceWire link transmitter
`timescale 1ns/1ps
`default_nettype none

module spw_tx_top import spw_tx_pkg::*;
#(
  parameter logic [divide_w-1:0] default_divide = 6'd9
)
(
  input  wire                 i_tx_clk,
  input  wire                 reset_in,
  input  wire                 i_tx_en,
  input  wire                 i_send_nulls,
  input  wire                 i_send_n_char,
  input  wire                 i_send_time_codes,
  input  wire  [divide_w-1:0] i_tx_clk_divide,
  input  wire                 i_tx_data_en,
  input  wire  [7:0]          i_tx_data,
  input  wire                 i_tx_data_control_flag,
  input  wire                 i_tick_in,
  input  wire  [time_w-1:0]   i_time_in,
  input  wire  [flags_w-1:0]  i_control_flags_in,
  input  wire                 i_fct_req,
  input  wire                 i_got_fct,
  output logic                o_space_wire_data_out,
  output logic                o_space_wire_strobe_out,
  output logic                o_tx_ready,
  output logic [credit_w-1:0] o_credit_count_out,
  output logic                o_credit_error
);

  // Internal links between the blocks
  logic       bit_tick;
  logic       char_load;
  char_kind_t next_kind;
  logic [7:0] next_data;
  logic       n_char_sent;
  logic       credit_zero;

  // Bit period generation
  spw_bit_rate_divider #(
    .default_divide (default_divide)
  ) spw_bit_rate_divider_inst (
    .i_tx_clk        (i_tx_clk),
    .reset_in        (reset_in),
    .i_send_n_char   (i_send_n_char),
    .i_tx_clk_divide (i_tx_clk_divide),
    .o_bit_tick      (bit_tick)
  );

  // Transmit credit bookkeeping
  spw_credit_counter spw_credit_counter_inst (
    .i_tx_clk       (i_tx_clk),
    .reset_in       (reset_in),
    .i_got_fct      (i_got_fct),
    .i_n_char_sent  (n_char_sent),
    .o_credit_count (o_credit_count_out),
    .o_credit_zero  (credit_zero),
    .o_credit_error (o_credit_error)
  );

  // Request buffering and character priority
  spw_char_scheduler spw_char_scheduler_inst (
    .i_tx_clk               (i_tx_clk),
    .reset_in               (reset_in),
    .i_send_nulls           (i_send_nulls),
    .i_send_n_char          (i_send_n_char),
    .i_send_time_codes      (i_send_time_codes),
    .i_tx_data_en           (i_tx_data_en),
    .i_tx_data              (i_tx_data),
    .i_tx_data_control_flag (i_tx_data_control_flag),
    .i_tick_in              (i_tick_in),
    .i_time_in              (i_time_in),
    .i_control_flags_in     (i_control_flags_in),
    .i_fct_req              (i_fct_req),
    .i_credit_zero          (credit_zero),
    .i_char_load            (char_load),
    .o_tx_ready             (o_tx_ready),
    .o_next_kind            (next_kind),
    .o_next_data            (next_data),
    .o_n_char_sent          (n_char_sent)
  );

  // Data-strobe line driver
  spw_ds_serializer spw_ds_serializer_inst (
    .i_tx_clk                (i_tx_clk),
    .reset_in                (reset_in),
    .i_tx_en                 (i_tx_en),
    .i_send_nulls            (i_send_nulls),
    .i_bit_tick              (bit_tick),
    .i_next_kind             (next_kind),
    .i_next_data             (next_data),
    .o_char_load             (char_load),
    .o_space_wire_data_out   (o_space_wire_data_out),
    .o_space_wire_strobe_out (o_space_wire_strobe_out)
  );

endmodule

`default_nettype wire

// ==== dv/spw_ds_monitor.sv ====
// Data-strobe line monitor
`timescale 1ns/1ps
`default_nettype none

module spw_ds_monitor
(
  input  wire         reset_in,
  input  wire         i_data,
  input  wire         i_strobe,
  output logic [31:0] o_char_count,
  output logic        o_char_ctrl,
  output logic [7:0]  o_char_bits,
  output logic        o_parity_error,
  output logic [31:0] o_bit_gap
);

  // Recovered clock is data xor strobe
  logic       prev_xor;
  int         bit_index;
  logic       parity_bit;
  logic       flag_bit;
  logic [7:0] payload;
  int         payload_len;
  // Payload parity of the character in progress and of the one before
  logic       payload_xor;
  logic       last_payload_xor;
  time        last_bit_time;

  task clear_state();
    begin
      prev_xor         = 1'b0;
      bit_index        = 0;
      parity_bit       = 1'b0;
      flag_bit         = 1'b0;
      payload          = '0;
      payload_len      = 0;
      payload_xor      = 1'b0;
      last_payload_xor = 1'b0;
      last_bit_time    = 0;
      o_char_count     = '0;
      o_char_ctrl      = 1'b0;
      o_char_bits      = '0;
      o_parity_error   = 1'b0;
      o_bit_gap        = '0;
    end
  endtask

  initial
  begin
    clear_state();
  end

  // ------------------------------
  // Bit recovery and character decode
  // ------------------------------
  always @(reset_in or i_data or i_strobe)
  begin
    if (reset_in)
    begin
      clear_state();
    end
    else if ((i_data ^ i_strobe) != prev_xor)
    begin
      // One line changed, so one new bit
      prev_xor      = i_data ^ i_strobe;
      o_bit_gap     = 32'($time - last_bit_time);
      last_bit_time = $time;
      if (bit_index == 0)
      begin
        parity_bit = i_data;
        bit_index  = 1;
      end
      else if (bit_index == 1)
      begin
        flag_bit = i_data;
        // Odd parity over previous payload, this parity bit and flag
        if ((parity_bit ^ flag_bit ^ last_payload_xor) != 1'b1)
          o_parity_error = 1'b1;
        payload_len = flag_bit ? 2 : 8;
        payload     = '0;
        payload_xor = 1'b0;
        bit_index   = 2;
      end
      else
      begin
        // First payload bit lands in bit 0
        payload[bit_index-2] = i_data;
        payload_xor          = payload_xor ^ i_data;
        bit_index            = bit_index + 1;
        if (bit_index - 2 == payload_len)
        begin
          last_payload_xor = payload_xor;
          o_char_ctrl      = flag_bit;
          o_char_bits      = payload;
          o_char_count     = o_char_count + 1;
          bit_index        = 0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/spw_tx_tb.sv ====
// SpaceWire transmitter testbench
`timescale 1ns/1ps
`default_nettype none

module spw_tx_tb import spw_tx_pkg::*;
();

  localparam int clk_period   = 4;
  localparam int start_divide = 9;
  localparam int fct_credit   = 8;
  localparam int credit_limit = 56;
  localparam int max_cases    = 64;
  // NULL pairs allowed ahead of a requested FCT
  localparam int fct_null_limit = 4;
  // Received control codes, first bit on the line in bit 0
  localparam logic [7:0] esc_bits = 8'h03;
  localparam logic [7:0] fct_bits = 8'h00;

  logic                i_tx_clk;
  logic                reset_in;
  logic                i_tx_en;
  logic                i_send_nulls;
  logic                i_send_n_char;
  logic                i_send_time_codes;
  logic [divide_w-1:0] i_tx_clk_divide;
  logic                i_tx_data_en;
  logic [7:0]          i_tx_data;
  logic                i_tx_data_control_flag;
  logic                i_tick_in;
  logic [time_w-1:0]   i_time_in;
  logic [flags_w-1:0]  i_control_flags_in;
  logic                i_fct_req;
  logic                i_got_fct;
  wire                 o_space_wire_data_out;
  wire                 o_space_wire_strobe_out;
  wire                 o_tx_ready;
  wire  [credit_w-1:0] o_credit_count_out;
  wire                 o_credit_error;

  wire  [31:0]         mon_char_count;
  wire                 mon_char_ctrl;
  wire  [7:0]          mon_char_bits;
  wire                 mon_parity_error;
  wire  [31:0]         mon_bit_gap;

  // Case memory and run state
  logic [31:0] case_mem [0:max_cases-1];
  logic [31:0] case_word;
  int          num_cases;
  int          case_index;
  logic        cases_loaded = 1'b0;
  longint      watchdog_ns;
  logic [31:0] lcg_state = 32'h1d46;
  int          credit_model;
  int          rate;
  logic [31:0] seen_count = '0;
  // Entry is gap, control flag, payload
  logic [40:0] rx_q [$];

  spw_tx_top #(
    .default_divide (divide_w'(start_divide))
  ) spw_tx_top_inst (
    .i_tx_clk                (i_tx_clk),
    .reset_in                (reset_in),
    .i_tx_en                 (i_tx_en),
    .i_send_nulls            (i_send_nulls),
    .i_send_n_char           (i_send_n_char),
    .i_send_time_codes       (i_send_time_codes),
    .i_tx_clk_divide         (i_tx_clk_divide),
    .i_tx_data_en            (i_tx_data_en),
    .i_tx_data               (i_tx_data),
    .i_tx_data_control_flag  (i_tx_data_control_flag),
    .i_tick_in               (i_tick_in),
    .i_time_in               (i_time_in),
    .i_control_flags_in      (i_control_flags_in),
    .i_fct_req               (i_fct_req),
    .i_got_fct               (i_got_fct),
    .o_space_wire_data_out   (o_space_wire_data_out),
    .o_space_wire_strobe_out (o_space_wire_strobe_out),
    .o_tx_ready              (o_tx_ready),
    .o_credit_count_out      (o_credit_count_out),
    .o_credit_error          (o_credit_error)
  );

  spw_ds_monitor spw_ds_monitor_inst (
    .reset_in       (reset_in),
    .i_data         (o_space_wire_data_out),
    .i_strobe       (o_space_wire_strobe_out),
    .o_char_count   (mon_char_count),
    .o_char_ctrl    (mon_char_ctrl),
    .o_char_bits    (mon_char_bits),
    .o_parity_error (mon_parity_error),
    .o_bit_gap      (mon_bit_gap)
  );

  initial
  begin
    i_tx_clk = 1'b0;
  end

  always #(clk_period / 2) i_tx_clk = ~i_tx_clk;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    begin
      if (actual !== expected)
      begin
        $display("CHECK FAILED time=%0t signal=%s actual=0x%0h expected=0x%0h",
                 $time, name, actual, expected);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  task automatic fail_run(input string reason);
    begin
      $display("ERROR at %0t: %s", $time, reason);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random idle of 0 to 7 cycles before a request
  task wait_random_gap();
    begin
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[18:16])
        @(negedge i_tx_clk);
    end
  endtask

  // Monitor characters are collected on the falling edge
  always @(negedge i_tx_clk)
  begin
    if (mon_char_count != seen_count)
    begin
      seen_count = mon_char_count;
      check_value("parity_error", mon_parity_error, 1'b0);
      rx_q.push_back({mon_bit_gap, mon_char_ctrl, mon_char_bits});
    end
  end

  task get_char(output logic ctrl, output logic [7:0] bits, output logic [31:0] gap);
    logic [40:0] entry;
    begin
      while (rx_q.size() == 0)
        @(negedge i_tx_clk);
      entry = rx_q.pop_front();
      gap   = entry[40:9];
      ctrl  = entry[8];
      bits  = entry[7:0];
    end
  endtask

  // Skips NULL pairs, flags a character that followed an ESC
  task next_non_null(output logic escaped, output logic ctrl, output logic [7:0] bits,
                     output logic [31:0] gap);
    logic found;
    begin
      found   = 1'b0;
      escaped = 1'b0;
      while (!found)
      begin
        get_char(ctrl, bits, gap);
        if (ctrl && bits == esc_bits)
        begin
          get_char(ctrl, bits, gap);
          if (!(ctrl && bits == fct_bits))
          begin
            found   = 1'b1;
            escaped = 1'b1;
          end
        end
        else
        begin
          found = 1'b1;
        end
      end
    end
  endtask

  task expect_nulls(input int count);
    logic        ctrl;
    logic [7:0]  bits;
    logic [31:0] gap;
    begin
      for (int n = 0; n < count; n++)
      begin
        get_char(ctrl, bits, gap);
        check_value("null_esc_flag", ctrl, 1'b1);
        check_value("null_esc_code", bits, esc_bits);
        get_char(ctrl, bits, gap);
        check_value("null_fct_flag", ctrl, 1'b1);
        check_value("null_fct_code", bits, fct_bits);
        check_value("bit_period_ns", gap, (start_divide + 1) * clk_period);
      end
    end
  endtask

  task pulse_got_fct(input int count);
    logic overflow;
    begin
      for (int n = 0; n < count; n++)
      begin
        overflow = (credit_model + fct_credit > credit_limit);
        if (!overflow)
          credit_model = credit_model + fct_credit;
        i_got_fct = 1'b1;
        @(negedge i_tx_clk);
        i_got_fct = 1'b0;
        check_value("o_credit_count_out", o_credit_count_out, credit_model);
        check_value("o_credit_error", o_credit_error, overflow);
        @(negedge i_tx_clk);
        check_value("o_credit_error", o_credit_error, 1'b0);
      end
    end
  endtask

  // Holds the byte until the ready handshake takes it
  task send_byte(input logic [7:0] value, input logic ctrl_flag);
    begin
      wait_random_gap();
      i_tx_data              = value;
      i_tx_data_control_flag = ctrl_flag;
      i_tx_data_en           = 1'b1;
      while (!o_tx_ready)
        @(negedge i_tx_clk);
      @(negedge i_tx_clk);
      i_tx_data_en = 1'b0;
    end
  endtask

  task expect_n_char(input logic exp_ctrl, input logic [7:0] exp_bits);
    logic        escaped;
    logic        ctrl;
    logic [7:0]  bits;
    logic [31:0] gap;
    begin
      next_non_null(escaped, ctrl, bits, gap);
      check_value("n_char_escaped", escaped, 1'b0);
      check_value("n_char_flag", ctrl, exp_ctrl);
      check_value("n_char_bits", bits, exp_bits);
      check_value("bit_period_ns", gap, (rate + 1) * clk_period);
      credit_model = credit_model - 1;
      check_value("o_credit_count_out", o_credit_count_out, credit_model);
      check_value("o_credit_error", o_credit_error, 1'b0);
    end
  endtask

  // Sends counting bytes until credit is used up, then holds one back
  task drain_credit(input logic [7:0] first_byte);
    logic [7:0] value;
    begin
      value = first_byte;
      while (credit_model > 0)
      begin
        send_byte(value, 1'b0);
        expect_n_char(1'b0, value);
        value = value + 8'd1;
      end
      i_tx_data    = 8'hee;
      i_tx_data_en = 1'b1;
      repeat (20)
      begin
        @(negedge i_tx_clk);
        check_value("o_tx_ready", o_tx_ready, 1'b0);
      end
      i_tx_data_en = 1'b0;
      check_value("o_credit_count_out", o_credit_count_out, 0);
    end
  endtask

  task send_time_code(input logic [7:0] code, input logic [7:0] exp_bits);
    logic        escaped;
    logic        ctrl;
    logic [7:0]  bits;
    logic [31:0] gap;
    begin
      wait_random_gap();
      i_send_time_codes  = 1'b1;
      i_control_flags_in = code[7:6];
      i_time_in          = code[5:0];
      i_tick_in          = 1'b1;
      @(negedge i_tx_clk);
      i_tick_in = 1'b0;
      next_non_null(escaped, ctrl, bits, gap);
      check_value("time_code_escaped", escaped, 1'b1);
      check_value("time_code_flag", ctrl, 1'b0);
      check_value("time_code_bits", bits, exp_bits);
    end
  endtask

  // An ESC before the FCT reads as a NULL, so only a few NULLs may pass first
  task request_fct(input logic [7:0] exp_bits);
    logic        found;
    int          nulls_seen;
    logic        ctrl;
    logic [7:0]  bits;
    logic [31:0] gap;
    begin
      wait_random_gap();
      i_fct_req = 1'b1;
      @(negedge i_tx_clk);
      i_fct_req  = 1'b0;
      found      = 1'b0;
      nulls_seen = 0;
      while (!found)
      begin
        get_char(ctrl, bits, gap);
        if (ctrl && bits == esc_bits)
        begin
          get_char(ctrl, bits, gap);
          if (!(ctrl && bits == fct_bits))
            fail_run("ESC ahead of the requested FCT was not part of a NULL");
          nulls_seen = nulls_seen + 1;
          if (nulls_seen > fct_null_limit)
            fail_run("requested FCT did not appear on its own after the request");
        end
        else
        begin
          found = 1'b1;
        end
      end
      check_value("fct_flag", ctrl, 1'b1);
      check_value("fct_bits", bits, exp_bits);
    end
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial
  begin
    wait (cases_loaded);
    #(watchdog_ns);
    fail_run("watchdog expired before all cases finished");
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    reset_in               = 1'b1;
    i_tx_en                = 1'b0;
    i_send_nulls           = 1'b1;
    i_send_n_char          = 1'b0;
    i_send_time_codes      = 1'b0;
    i_tx_clk_divide        = divide_w'(start_divide);
    i_tx_data_en           = 1'b0;
    i_tx_data              = '0;
    i_tx_data_control_flag = 1'b0;
    i_tick_in              = 1'b0;
    i_time_in              = '0;
    i_control_flags_in     = '0;
    i_fct_req              = 1'b0;
    i_got_fct              = 1'b0;
    credit_model           = 0;
    rate                   = start_divide;

    for (int n = 0; n < max_cases; n++)
      case_mem[n] = '0;
    $readmemh("dv/spw_tx_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < max_cases && case_mem[num_cases][31:28] != 4'h0)
      num_cases = num_cases + 1;
    if (num_cases == 0)
      fail_run("no cases read from dv/spw_tx_cases.txt");
    // Ten bit periods per case at start-up rate, four times over
    watchdog_ns  = longint'(num_cases) * 10 * (start_divide + 1) * clk_period * 4;
    cases_loaded = 1'b1;

    repeat (2)
      @(negedge i_tx_clk);
    reset_in = 1'b0;
    check_value("o_space_wire_data_out", o_space_wire_data_out, 1'b0);
    check_value("o_space_wire_strobe_out", o_space_wire_strobe_out, 1'b0);
    check_value("o_tx_ready", o_tx_ready, 1'b0);
    check_value("o_credit_count_out", o_credit_count_out, 0);
    check_value("o_credit_error", o_credit_error, 1'b0);

    // Link disabled, lines must stay quiet
    repeat (4 * (start_divide + 1))
    begin
      @(negedge i_tx_clk);
      check_value("o_space_wire_data_out", o_space_wire_data_out, 1'b0);
      check_value("o_space_wire_strobe_out", o_space_wire_strobe_out, 1'b0);
    end
    check_value("monitor_char_count", mon_char_count, 0);
    i_tx_en = 1'b1;

    for (case_index = 0; case_index < num_cases; case_index++)
    begin
      case_word = case_mem[case_index];
      case (case_word[31:28])
        4'h1: expect_nulls(case_word[23:16]);
        4'h2:
        begin
          send_byte(case_word[23:16], case_word[24]);
          expect_n_char(case_word[12], case_word[7:0]);
        end
        4'h3:
        begin
          // New rate takes over with N-Chars enabled
          i_tx_clk_divide = case_word[16 +: divide_w];
          i_send_n_char   = 1'b1;
          rate            = case_word[16 +: divide_w];
          @(negedge i_tx_clk);
        end
        4'h4: pulse_got_fct(case_word[23:16]);
        4'h5: drain_credit(case_word[23:16]);
        4'h6: send_time_code(case_word[23:16], case_word[7:0]);
        4'h7: request_fct(case_word[7:0]);
        default: fail_run("unknown opcode in the cases file");
      endcase
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/spw_tx_pkg.sv
hw/spw_bit_rate_divider.sv
hw/spw_credit_counter.sv
encoder/spw_char_scheduler.sv
encoder/spw_ds_serializer.sv
hw/spw_tx_top.sv
dv/spw_ds_monitor.sv
dv/spw_tx_tb.sv

// ==== dv/spw_tx_cases.txt ====
// Word: op[31:28] flag[27:24] arg[23:16] exp_ctrl[15:12] pad[11:8] exp_bits[7:0]
// Ops: 1 nulls, 2 n-char, 3 rate, 4 got_fct, 5 drain, 6 time-code, 7 fct request, 0 end
10040000
40020000
30020000
205A005A
20A500A5
20FF00FF
20000000
21001002
203C003C
21011001
20810081
50400000
40070000
40010000
60950095
70001000
606A006A
00000000
